// ==== Makefile ====
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_noc_arbiter
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/nexthop_if.sv ====
`default_nettype none

// Next-hop port of every input, as held in the route stage registers
interface nexthop_if;

	import noc_arbiter_pkg::*;

	// Indexed by input port
	port_e hop [NUM_PORTS];

	modport producer (
		output hop
	);

	modport consumer (
		input hop
	);

endinterface

`default_nettype wire

// ==== hw/noc_arbiter.sv ====
`default_nettype none

module noc_arbiter (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    router_addr_i,

	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    hdr_n_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    hdr_s_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    hdr_w_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    hdr_e_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0]    hdr_l_i,

	input  logic                                 nhr_write_n_i,
	input  logic                                 nhr_write_s_i,
	input  logic                                 nhr_write_w_i,
	input  logic                                 nhr_write_e_i,
	input  logic                                 nhr_write_l_i,

	input  logic                                 change_order_n_i,
	input  logic                                 change_order_s_i,
	input  logic                                 change_order_w_i,
	input  logic                                 change_order_e_i,
	input  logic                                 change_order_l_i,

	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_n_o,
	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_s_o,
	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_w_o,
	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_e_o,
	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_l_o,

	output logic                                 to_cs_n_o,
	output logic                                 to_cs_s_o,
	output logic                                 to_cs_w_o,
	output logic                                 to_cs_e_o,
	output logic                                 to_cs_l_o
);

	import noc_arbiter_pkg::*;

	logic [ADDR_W-1:0]    hdr [NUM_PORTS];
	logic [NUM_PORTS-1:0] nhr_write;

	nexthop_if nh_if ();

	// --------------------
	// Route stage
	// --------------------

	// Vectors are indexed by the port enum value
	assign hdr[P_N] = hdr_n_i;
	assign hdr[P_S] = hdr_s_i;
	assign hdr[P_W] = hdr_w_i;
	assign hdr[P_E] = hdr_e_i;
	assign hdr[P_L] = hdr_l_i;

	assign nhr_write = {nhr_write_l_i, nhr_write_e_i, nhr_write_w_i, nhr_write_s_i, nhr_write_n_i};

	route_stage u_route (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.router_addr_i (router_addr_i),
		.hdr_i         (hdr),
		.write_i       (nhr_write),
		.nh            (nh_if.producer)
	);

	// --------------------
	// Output arbiters
	// --------------------

	rr_output_arbiter #(.OWN_PORT(P_N)) u_arb_n (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.nh             (nh_if.consumer),
		.change_order_i (change_order_n_i),
		.grant_o        (grant_n_o),
		.to_cs_o        (to_cs_n_o)
	);

	rr_output_arbiter #(.OWN_PORT(P_S)) u_arb_s (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.nh             (nh_if.consumer),
		.change_order_i (change_order_s_i),
		.grant_o        (grant_s_o),
		.to_cs_o        (to_cs_s_o)
	);

	rr_output_arbiter #(.OWN_PORT(P_W)) u_arb_w (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.nh             (nh_if.consumer),
		.change_order_i (change_order_w_i),
		.grant_o        (grant_w_o),
		.to_cs_o        (to_cs_w_o)
	);

	rr_output_arbiter #(.OWN_PORT(P_E)) u_arb_e (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.nh             (nh_if.consumer),
		.change_order_i (change_order_e_i),
		.grant_o        (grant_e_o),
		.to_cs_o        (to_cs_e_o)
	);

	rr_output_arbiter #(.OWN_PORT(P_L)) u_arb_l (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.nh             (nh_if.consumer),
		.change_order_i (change_order_l_i),
		.grant_o        (grant_l_o),
		.to_cs_o        (to_cs_l_o)
	);

endmodule

`default_nettype wire

// ==== hw/noc_arbiter_pkg.sv ====
`default_nettype none

package noc_arbiter_pkg;

	// --------------------
	// Router geometry
	// --------------------

	localparam int NUM_PORTS = 5;
	localparam int ADDR_W = 8;
	localparam int COORD_W = 4;

	// Value doubles as the index into grant and request vectors
	typedef enum logic [2:0] {
		P_N    = 3'd0,
		P_S    = 3'd1,
		P_W    = 3'd2,
		P_E    = 3'd3,
		P_L    = 3'd4,
		P_NONE = 3'd7
	} port_e;

	// --------------------
	// YX routing
	// --------------------

	// Y is resolved first, then X, and a full match ejects to the local port
	function automatic port_e yx_route(
		input logic [ADDR_W-1:0] hdr_addr,
		input logic [ADDR_W-1:0] router_addr
	);
		logic [COORD_W-1:0] dst_y;
		logic [COORD_W-1:0] dst_x;
		logic [COORD_W-1:0] cur_y;
		logic [COORD_W-1:0] cur_x;
		dst_y = hdr_addr[ADDR_W-1 -: COORD_W];
		dst_x = hdr_addr[COORD_W-1:0];
		cur_y = router_addr[ADDR_W-1 -: COORD_W];
		cur_x = router_addr[COORD_W-1:0];
		if (dst_y != cur_y) begin
			return (dst_y > cur_y) ? P_N : P_S;
		end
		if (dst_x != cur_x) begin
			return (dst_x > cur_x) ? P_E : P_W;
		end
		return P_L;
	endfunction

endpackage

`default_nettype wire

// ==== hw/route_stage.sv ====
`default_nettype none

module route_stage (
	input  logic                              clk,
	input  logic                              arst_n_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0] router_addr_i,
	input  logic [noc_arbiter_pkg::ADDR_W-1:0] hdr_i [noc_arbiter_pkg::NUM_PORTS],
	input  logic [noc_arbiter_pkg::NUM_PORTS-1:0] write_i,
	nexthop_if.producer                       nh
);

	import noc_arbiter_pkg::*;

	port_e hop_q [NUM_PORTS];

	// --------------------
	// Next-hop registers
	// --------------------

	// A register keeps its hop until the next write on that input
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				hop_q[i] <= P_NONE;
			end
		end else begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (write_i[i]) begin
					hop_q[i] <= yx_route(hdr_i[i], router_addr_i);
				end
			end
		end
	end

	assign nh.hop = hop_q;

	// --------------------
	// Checks
	// --------------------

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
		// Once written, an input always names a real output port
		a_written_not_none: assert property (
			@(posedge clk) disable iff (!arst_n_i)
			write_i[i] |=> (nh.hop[i] != P_NONE)
		) else $error("route_stage: input %0d holds P_NONE after a write", i);
	end

endmodule

`default_nettype wire

// ==== hw/rr_output_arbiter.sv ====
`default_nettype none

module rr_output_arbiter #(
	parameter noc_arbiter_pkg::port_e OWN_PORT = noc_arbiter_pkg::P_N
) (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	nexthop_if.consumer                          nh,
	input  logic                                 change_order_i,
	output logic [noc_arbiter_pkg::NUM_PORTS-1:0] grant_o,
	output logic                                 to_cs_o
);

	import noc_arbiter_pkg::*;

	localparam int PTR_W = $clog2(NUM_PORTS);

	logic [NUM_PORTS-1:0] req;
	logic [PTR_W-1:0]     ptr_q;
	logic [PTR_W-1:0]     win_idx;
	logic                 win_vld;

	// --------------------
	// Requests
	// --------------------

	// An input asks for this output when its next hop names it and it is not a U-turn
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
		if (i == int'(OWN_PORT)) begin : g_own
			assign req[i] = 1'b0;
		end else begin : g_other
			assign req[i] = (nh.hop[i] == OWN_PORT);
		end

		// A granted input must still point at this output in the route stage
		a_grant_has_hop: assert property (
			@(posedge clk) disable iff (!arst_n_i)
			grant_o[i] |-> (nh.hop[i] == OWN_PORT)
		) else $error("arbiter %0d: grant to input %0d without a request", OWN_PORT, i);
	end

	// --------------------
	// Round-robin search
	// --------------------

	// The first requester at or after the pointer wins and the search wraps past the last port
	always_comb begin
		int idx;
		win_vld = 1'b0;
		win_idx = ptr_q;
		for (int k = 0; k < NUM_PORTS; k++) begin
			idx = int'(ptr_q) + k;
			if (idx >= NUM_PORTS) begin
				idx = idx - NUM_PORTS;
			end
			if (!win_vld && req[idx]) begin
				win_vld = 1'b1;
				win_idx = PTR_W'(idx);
			end
		end
	end

	assign grant_o = win_vld ? (NUM_PORTS'(1) << win_idx) : '0;
	assign to_cs_o = win_vld;

	// Pointer moves one past the current winner
	// A pulse without a winner is ignored
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ptr_q <= '0;
		end else if (change_order_i && win_vld) begin
			if (win_idx == PTR_W'(NUM_PORTS - 1)) begin
				ptr_q <= '0;
			end else begin
				ptr_q <= win_idx + 1'b1;
			end
		end
	end

	// --------------------
	// Checks
	// --------------------

	a_grant_onehot0: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		$onehot0(grant_o)
	) else $error("arbiter %0d: more than one grant", OWN_PORT);

	a_no_uturn: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!grant_o[OWN_PORT]
	) else $error("arbiter %0d: own port granted", OWN_PORT);

endmodule

`default_nettype wire

// ==== src.f ====
hw/noc_arbiter_pkg.sv
hw/nexthop_if.sv
hw/route_stage.sv
hw/rr_output_arbiter.sv
hw/noc_arbiter.sv
tests/tb_noc_arbiter.sv

// ==== tests/tb_noc_arbiter.sv ====
`default_nettype none

module tb_noc_arbiter;

	import noc_arbiter_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_RANDOM = 200;

	typedef struct packed {
		logic [ADDR_W-1:0]                   rtr;
		logic [NUM_PORTS-1:0][ADDR_W-1:0]    hdr;
		logic [NUM_PORTS-1:0]                wr;
		logic [NUM_PORTS-1:0]                co;
		logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;
		logic [NUM_PORTS-1:0]                to_cs;
	} row_t;

	logic                 clk;
	logic                 arst_n_i;
	logic [ADDR_W-1:0]    router_addr;
	logic [ADDR_W-1:0]    hdr [NUM_PORTS];
	logic [NUM_PORTS-1:0] wr;
	logic [NUM_PORTS-1:0] co;
	logic [NUM_PORTS-1:0] grant [NUM_PORTS];
	logic                 to_cs [NUM_PORTS];

	// Reference model state
	port_e       hop_m [NUM_PORTS];
	int          ptr_m [NUM_PORTS];
	row_t        table_q [$];
	logic [31:0] rng;

	noc_arbiter DUT (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.router_addr_i    (router_addr),
		.hdr_n_i          (hdr[P_N]),
		.hdr_s_i          (hdr[P_S]),
		.hdr_w_i          (hdr[P_W]),
		.hdr_e_i          (hdr[P_E]),
		.hdr_l_i          (hdr[P_L]),
		.nhr_write_n_i    (wr[P_N]),
		.nhr_write_s_i    (wr[P_S]),
		.nhr_write_w_i    (wr[P_W]),
		.nhr_write_e_i    (wr[P_E]),
		.nhr_write_l_i    (wr[P_L]),
		.change_order_n_i (co[P_N]),
		.change_order_s_i (co[P_S]),
		.change_order_w_i (co[P_W]),
		.change_order_e_i (co[P_E]),
		.change_order_l_i (co[P_L]),
		.grant_n_o        (grant[P_N]),
		.grant_s_o        (grant[P_S]),
		.grant_w_o        (grant[P_W]),
		.grant_e_o        (grant[P_E]),
		.grant_l_o        (grant[P_L]),
		.to_cs_n_o        (to_cs[P_N]),
		.to_cs_s_o        (to_cs[P_S]),
		.to_cs_w_o        (to_cs[P_W]),
		.to_cs_e_o        (to_cs[P_E]),
		.to_cs_l_o        (to_cs[P_L])
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------
	// Reference model
	// --------------------

	// Signed coordinate distance with Y resolved first
	function automatic port_e route_ref(
		input logic [ADDR_W-1:0] dst,
		input logic [ADDR_W-1:0] here
	);
		int dy;
		int dx;
		dy = int'(dst[ADDR_W-1:COORD_W]) - int'(here[ADDR_W-1:COORD_W]);
		dx = int'(dst[COORD_W-1:0]) - int'(here[COORD_W-1:0]);
		if (dy > 0) return P_N;
		if (dy < 0) return P_S;
		if (dx > 0) return P_E;
		if (dx < 0) return P_W;
		return P_L;
	endfunction

	function automatic logic [NUM_PORTS-1:0] grant_ref(input int out);
		int i;
		for (int k = 0; k < NUM_PORTS; k++) begin
			i = (ptr_m[out] + k) % NUM_PORTS;
			if (i != out && hop_m[i] == port_e'(out)) return NUM_PORTS'(1) << i;
		end
		return '0;
	endfunction

	// A pulse acts on the grant seen before the edge while writes land at the same edge
	task automatic model_step(inout row_t r, input bit fill);
		logic [NUM_PORTS-1:0] g;
		for (int o = 0; o < NUM_PORTS; o++) begin
			g = grant_ref(o);
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (r.co[o] && g[i]) ptr_m[o] = (i + 1) % NUM_PORTS;
			end
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (r.wr[i]) hop_m[i] = route_ref(r.hdr[i], r.rtr);
		end
		if (fill) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				r.grant[o] = grant_ref(o);
				r.to_cs[o] = |r.grant[o];
			end
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------
	// Stimulus table
	// --------------------

	task automatic add_row(
		input logic [ADDR_W-1:0] rtr,
		input logic [ADDR_W-1:0] h_n, h_s, h_w, h_e, h_l,
		input logic [NUM_PORTS-1:0] wr_m, co_m,
		input logic [NUM_PORTS-1:0] g_n, g_s, g_w, g_e, g_l,
		input logic [NUM_PORTS-1:0] cs
	);
		row_t r;
		r.rtr = rtr;
		r.hdr = {h_l, h_e, h_w, h_s, h_n};
		r.wr = wr_m;
		r.co = co_m;
		r.grant = {g_l, g_e, g_w, g_s, g_n};
		r.to_cs = cs;
		table_q.push_back(r);
	endtask

	task automatic build_table();
		row_t r;
		// Router, headers N S W E L, write mask, pulse mask, grants N S W E L, to_cs mask
		add_row(8'h22, 8'h52, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00001, 5'b00000,
			5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000);
		add_row(8'h22, 8'h12, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00001, 5'b00000,
			5'b00000, 5'b00001, 5'b00000, 5'b00000, 5'b00000, 5'b00010);
		add_row(8'h22, 8'h00, 8'h25, 8'h00, 8'h00, 8'h00, 5'b00010, 5'b00000,
			5'b00000, 5'b00001, 5'b00000, 5'b00010, 5'b00000, 5'b01010);
		add_row(8'h22, 8'h00, 8'h00, 8'h22, 8'h00, 8'h00, 5'b00100, 5'b00000,
			5'b00000, 5'b00001, 5'b00000, 5'b00010, 5'b00100, 5'b11010);
		add_row(8'h22, 8'h00, 8'h00, 8'h00, 8'h20, 8'h00, 5'b01000, 5'b00000,
			5'b00000, 5'b00001, 5'b01000, 5'b00010, 5'b00100, 5'b11110);
		add_row(8'h22, 8'h00, 8'h00, 8'h00, 8'h00, 8'h72, 5'b10000, 5'b00000,
			5'b10000, 5'b00001, 5'b01000, 5'b00010, 5'b00100, 5'b11111);
		// North input turns back on itself while East joins the North output
		add_row(8'h22, 8'h92, 8'h00, 8'h00, 8'h62, 8'h00, 5'b01001, 5'b00000,
			5'b01000, 5'b00000, 5'b00000, 5'b00010, 5'b00100, 5'b11001);
		add_row(8'h22, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000, 5'b00011,
			5'b10000, 5'b00000, 5'b00000, 5'b00010, 5'b00100, 5'b11001);
		add_row(8'h22, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000, 5'b00001,
			5'b01000, 5'b00000, 5'b00000, 5'b00010, 5'b00100, 5'b11001);
		add_row(8'h22, 8'h12, 8'h00, 8'h02, 8'h00, 8'h00, 5'b00101, 5'b00000,
			5'b01000, 5'b00001, 5'b00000, 5'b00010, 5'b00000, 5'b01011);
		add_row(8'h22, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000, 5'b00010,
			5'b01000, 5'b00100, 5'b00000, 5'b00010, 5'b00000, 5'b01011);
		add_row(8'h55, 8'hab, 8'hcd, 8'h37, 8'h11, 8'h22, 5'b00000, 5'b00000,
			5'b01000, 5'b00100, 5'b00000, 5'b00010, 5'b00000, 5'b01011);

		for (int i = 0; i < NUM_PORTS; i++) begin
			hop_m[i] = P_NONE;
			ptr_m[i] = 0;
		end
		foreach (table_q[j]) begin
			r = table_q[j];
			model_step(r, 1'b0);
		end
		// Headers often share a coordinate with the router so all outputs see traffic
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng = xorshift(rng);
			r.rtr = rng[7:0];
			for (int i = 0; i < NUM_PORTS; i++) begin
				rng = xorshift(rng);
				r.hdr[i] = rng[7:0];
				if (rng[8]) r.hdr[i][ADDR_W-1:COORD_W] = r.rtr[ADDR_W-1:COORD_W];
				if (rng[9]) r.hdr[i][COORD_W-1:0] = r.rtr[COORD_W-1:0];
			end
			rng = xorshift(rng);
			r.wr = rng[4:0];
			r.co = rng[9:5];
			model_step(r, 1'b1);
			table_q.push_back(r);
		end
	endtask

	// --------------------
	// Checks and waits
	// --------------------

	task automatic stop_on_error(input string why);
		$display("STATUS: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_grant(input string what, input logic [NUM_PORTS-1:0] got,
		input logic [NUM_PORTS-1:0] exp);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s grant is %b, expected %b", $time, what, got, exp);
			stop_on_error("grant mismatch");
		end
	endtask

	task automatic check_to_cs(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s to_cs is %b, expected %b", $time, what, got, exp);
			stop_on_error("to_cs mismatch");
		end
	endtask

	task automatic check_outputs(input row_t r, input string what);
		for (int o = 0; o < NUM_PORTS; o++) begin
			check_grant($sformatf("%s output %0d", what, o), grant[o], r.grant[o]);
			check_to_cs($sformatf("%s output %0d", what, o), to_cs[o], r.to_cs[o]);
		end
	endtask

	task automatic wait_cycles(input int n);
		int  seen;
		time deadline;
		seen = 0;
		deadline = $time + 64'((n + 1) * CLK_PERIOD);
		while (seen < n) begin
			fork
				@(posedge clk);
				#(2 * CLK_PERIOD);
			join_any
			if ($time > deadline) begin
				$display("Timeout: %0d clock edges did not arrive in time", n);
				stop_on_error("clock wait timed out");
			end
			seen++;
		end
	endtask

	task automatic drive_row(input row_t r);
		router_addr = r.rtr;
		for (int i = 0; i < NUM_PORTS; i++) begin
			hdr[i] = r.hdr[i];
		end
		wr = r.wr;
		co = r.co;
	endtask

	initial begin
		#((NUM_RANDOM + 100) * CLK_PERIOD * 2);
		$display("Timeout: the run did not reach its end");
		stop_on_error("simulation timed out");
	end

	initial begin
		row_t idle;
		idle = '0;
		rng = 32'd76767;
		arst_n_i = 1'b0;
		drive_row(idle);
		build_table();
		wait_cycles(10);
		#2;
		arst_n_i = 1'b1;
		wait_cycles(1);
		#1;
		check_outputs(idle, "after reset");
		#1;
		foreach (table_q[j]) begin
			drive_row(table_q[j]);
			wait_cycles(1);
			#1;
			check_outputs(table_q[j], $sformatf("row %0d", j));
			#1;
		end
		drive_row(idle);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
